/* rtl/ex_pkg.sv */
package ex_pkg;

    localparam int div_steps = 32;  // one quotient bit per cycle

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_nor  = 4'd5,
        alu_sll  = 4'd6,
        alu_srl  = 4'd7,
        alu_sra  = 4'd8,
        alu_slt  = 4'd9,
        alu_sltu = 4'd10,
        alu_mul  = 4'd11,  // low half of product
        alu_div  = 4'd12,
        alu_divu = 4'd13,
        alu_mod  = 4'd14,
        alu_modu = 4'd15
    } alu_op_t;

    // same coding as data_sram_size
    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_t     alu_op;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] rkd;           // store data source
        logic        mem_rd;        // load
        logic        mem_we;        // store
        mem_size_t   mem_size;
        logic        mem_unsigned;  // zero-extend load, used in mem stage
        logic        rf_we;
        logic [4:0]  rf_waddr;
    } ex_uop_t;

endpackage

/* rtl/ex_alu_if.sv */
`timescale 1ns/1ps

interface ex_alu_if #(
    parameter int xlen = 32
);

    ex_pkg::alu_op_t op;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic            start;     // first cycle of a new op
    logic [xlen-1:0] result;
    logic            complete;  // level, held until next start

    modport ctrl (
        output op,
        output src1,
        output src2,
        output start,
        input  result,
        input  complete
    );

    modport alu (
        input  op,
        input  src1,
        input  src2,
        input  start,
        output result,
        output complete
    );

endinterface

/* rtl/ex_ctrl.sv */
`timescale 1ns/1ps

module ex_ctrl (
    input  logic             clk,
    input  logic             resetn,
    input  logic             id_valid,
    input  ex_pkg::ex_uop_t  id_uop,
    output logic             ex_allowin,
    input  logic             flush,
    input  logic             mem_allowin,
    output logic             mem_valid,
    input  logic             mem_issue_done,
    output logic             stage_valid,
    output ex_pkg::ex_uop_t  uop,
    ex_alu_if.ctrl           alu
);

    logic first_cycle;  // uop entered on the last edge
    logic ready_go;
    logic accept;

    assign accept     = id_valid & ex_allowin;
    assign ready_go   = alu.complete & mem_issue_done;
    assign ex_allowin = ~stage_valid | (ready_go & mem_allowin);
    assign mem_valid  = stage_valid & ready_go & ~flush;  // killed uop never leaves

    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage_valid <= 1'b0;
        end else if (flush) begin
            stage_valid <= 1'b0;
        end else if (ex_allowin) begin
            stage_valid <= id_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            uop <= id_uop;
        end
    end

    // a flush also cancels the pending start
    always_ff @(posedge clk) begin
        if (!resetn) begin
            first_cycle <= 1'b0;
        end else begin
            first_cycle <= accept & ~flush;
        end
    end

    // operands come straight from the held uop
    assign alu.op    = uop.alu_op;
    assign alu.src1  = uop.src1;
    assign alu.src2  = uop.src2;
    assign alu.start = first_cycle;  // also restarts an old divide

endmodule

/* rtl/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu #(
    parameter int xlen = 32
) (
    input  logic  clk,
    input  logic  resetn,
    ex_alu_if.alu port
);

    localparam int sh_w  = $clog2(xlen);
    localparam int cnt_w = $clog2(ex_pkg::div_steps + 1);

    logic [sh_w-1:0]  shamt;
    logic [xlen-1:0]  fast_res;
    logic             is_div;
    logic             is_signed_div;
    logic             want_rem;
    logic             a_neg;
    logic             b_neg;
    logic [xlen:0]    rem_sh;
    logic [xlen:0]    diff;
    logic [xlen-1:0]  rem_q;
    logic [xlen-1:0]  quo_q;  // dividend shifts out as quotient shifts in
    logic [xlen-1:0]  dsr_q;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             dz_q;
    logic             busy;
    logic             done;
    logic [cnt_w-1:0] cnt;
    logic [xlen-1:0]  quo_fix;
    logic [xlen-1:0]  rem_fix;

    assign shamt = port.src2[sh_w-1:0];

    always_comb begin
        unique case (port.op)
            ex_pkg::alu_add:  fast_res = port.src1 + port.src2;
            ex_pkg::alu_sub:  fast_res = port.src1 - port.src2;
            ex_pkg::alu_and:  fast_res = port.src1 & port.src2;
            ex_pkg::alu_or:   fast_res = port.src1 | port.src2;
            ex_pkg::alu_xor:  fast_res = port.src1 ^ port.src2;
            ex_pkg::alu_nor:  fast_res = ~(port.src1 | port.src2);
            ex_pkg::alu_sll:  fast_res = port.src1 << shamt;
            ex_pkg::alu_srl:  fast_res = port.src1 >> shamt;
            ex_pkg::alu_sra:  fast_res = $signed(port.src1) >>> shamt;
            ex_pkg::alu_slt:  fast_res = xlen'($signed(port.src1) < $signed(port.src2));
            ex_pkg::alu_sltu: fast_res = xlen'(port.src1 < port.src2);
            ex_pkg::alu_mul:  fast_res = port.src1 * port.src2;
            default:          fast_res = '0;  // divide ops
        endcase
    end

    assign is_div = port.op inside {ex_pkg::alu_div, ex_pkg::alu_divu,
                                    ex_pkg::alu_mod, ex_pkg::alu_modu};
    assign is_signed_div = port.op inside {ex_pkg::alu_div, ex_pkg::alu_mod};
    assign want_rem      = port.op inside {ex_pkg::alu_mod, ex_pkg::alu_modu};
    assign a_neg = is_signed_div & port.src1[xlen-1];
    assign b_neg = is_signed_div & port.src2[xlen-1];

    // restoring step keeps the trial subtract when there is no borrow
    assign rem_sh = {rem_q, quo_q[xlen-1]};
    assign diff   = rem_sh - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else if (port.start) begin
            busy <= is_div;
            done <= 1'b0;
            cnt  <= cnt_w'(ex_pkg::div_steps);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == cnt_w'(1)) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (port.start) begin
            rem_q   <= '0;
            quo_q   <= a_neg ? -port.src1 : port.src1;  // magnitudes only
            dsr_q   <= b_neg ? -port.src2 : port.src2;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;                           // remainder takes dividend sign
            dz_q    <= (port.src2 == '0);
        end else if (busy) begin
            if (!diff[xlen]) begin
                rem_q <= diff[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b1};
            end else begin
                rem_q <= rem_sh[xlen-1:0];
                quo_q <= {quo_q[xlen-2:0], 1'b0};
            end
        end
    end

    // divide by zero gives all ones and leaves the dividend as remainder
    assign quo_fix = dz_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign rem_fix = r_neg_q ? -rem_q : rem_q;

    assign port.result   = is_div ? (want_rem ? rem_fix : quo_fix) : fast_res;
    assign port.complete = is_div ? (done & ~port.start) : 1'b1;

endmodule

/* rtl/ex_mem_req.sv */
`timescale 1ns/1ps

module ex_mem_req #(
    parameter int xlen = 32
) (
    input  logic              stage_valid,
    input  ex_pkg::ex_uop_t   uop,
    input  logic [xlen-1:0]   addr,  // alu sum
    input  logic              flush,
    input  logic              mem_allowin,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [1:0]        data_sram_size,
    output logic [xlen/8-1:0] data_sram_wstrb,
    output logic [xlen-1:0]   data_sram_addr,
    output logic [xlen-1:0]   data_sram_wdata,
    input  logic              data_sram_addr_ok,
    output logic              mem_issue_done,
    output logic              ale
);

    localparam int nb    = xlen / 8;
    localparam int off_w = $clog2(nb);

    logic             is_mem;
    logic             need_access;
    logic [off_w-1:0] off;

    assign is_mem = uop.mem_rd | uop.mem_we;
    assign off    = addr[off_w-1:0];

    assign ale = is_mem & (((uop.mem_size == ex_pkg::size_half) & addr[0])
                         | ((uop.mem_size == ex_pkg::size_word) & (|addr[1:0])));

    assign need_access = stage_valid & is_mem & ~ale;
    // held off under back-pressure so a store issues once
    assign data_sram_req  = need_access & ~flush & mem_allowin;
    assign mem_issue_done = ~need_access | (data_sram_req & data_sram_addr_ok);

    assign data_sram_wr   = uop.mem_we;
    assign data_sram_size = uop.mem_size;
    assign data_sram_addr = addr;

    always_comb begin
        case (uop.mem_size)
            ex_pkg::size_byte: begin
                data_sram_wstrb = nb'(1) << off;
                data_sram_wdata = {nb{uop.rkd[7:0]}};
            end
            ex_pkg::size_half: begin
                data_sram_wstrb = nb'(2'b11) << (off & ~off_w'(1));  // 0011 or 1100
                data_sram_wdata = {(nb / 2){uop.rkd[15:0]}};
            end
            ex_pkg::size_word: begin
                data_sram_wstrb = nb'(4'b1111) << (off & ~off_w'(3));
                data_sram_wdata = {(nb / 4){uop.rkd[31:0]}};
            end
            default: begin
                data_sram_wstrb = '0;
                data_sram_wdata = '0;
            end
        endcase
    end

endmodule

/* rtl/ex_top.sv */
`timescale 1ns/1ps

module ex_top #(
    parameter int xlen = 32
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              id_valid,
    input  logic [31:0]       in_pc,
    input  logic [3:0]        in_alu_op,
    input  logic [31:0]       in_src1,
    input  logic [31:0]       in_src2,
    input  logic [31:0]       in_rkd,
    input  logic              in_mem_rd,
    input  logic              in_mem_we,
    input  logic [1:0]        in_mem_size,
    input  logic              in_mem_unsigned,
    input  logic              in_rf_we,
    input  logic [4:0]        in_rf_waddr,
    output logic              ex_allowin,
    input  logic              flush,
    input  logic              mem_allowin,
    output logic              mem_valid,
    output logic [31:0]       out_pc,
    output logic [xlen-1:0]   out_result,
    output logic              out_rf_we,
    output logic [4:0]        out_rf_waddr,
    output logic              out_mem_rd,
    output logic              out_mem_unsigned,
    output logic              out_ale,
    output logic              data_sram_req,
    output logic              data_sram_wr,
    output logic [1:0]        data_sram_size,
    output logic [xlen/8-1:0] data_sram_wstrb,
    output logic [xlen-1:0]   data_sram_addr,
    output logic [xlen-1:0]   data_sram_wdata,
    input  logic              data_sram_addr_ok
);

    ex_pkg::ex_uop_t id_uop;
    ex_pkg::ex_uop_t uop;
    logic            stage_valid;
    logic            mem_issue_done;

    ex_alu_if #(.xlen(xlen)) alu_bus ();

    always_comb begin
        id_uop.pc           = in_pc;
        id_uop.alu_op       = ex_pkg::alu_op_t'(in_alu_op);
        id_uop.src1         = in_src1;
        id_uop.src2         = in_src2;
        id_uop.rkd          = in_rkd;
        id_uop.mem_rd       = in_mem_rd;
        id_uop.mem_we       = in_mem_we;
        id_uop.mem_size     = ex_pkg::mem_size_t'(in_mem_size);
        id_uop.mem_unsigned = in_mem_unsigned;
        id_uop.rf_we        = in_rf_we;
        id_uop.rf_waddr     = in_rf_waddr;
    end

    ex_ctrl ex_ctrl_i (
        .clk            (clk),
        .resetn         (resetn),
        .id_valid       (id_valid),
        .id_uop         (id_uop),
        .ex_allowin     (ex_allowin),
        .flush          (flush),
        .mem_allowin    (mem_allowin),
        .mem_valid      (mem_valid),
        .mem_issue_done (mem_issue_done),
        .stage_valid    (stage_valid),
        .uop            (uop),
        .alu            (alu_bus.ctrl)
    );

    ex_alu #(.xlen(xlen)) ex_alu_i (
        .clk    (clk),
        .resetn (resetn),
        .port   (alu_bus.alu)
    );

    ex_mem_req #(.xlen(xlen)) ex_mem_req_i (
        .stage_valid       (stage_valid),
        .uop               (uop),
        .addr              (alu_bus.result),  // effective address from add
        .flush             (flush),
        .mem_allowin       (mem_allowin),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok),
        .mem_issue_done    (mem_issue_done),
        .ale               (out_ale)
    );

    assign out_pc           = uop.pc;
    assign out_result       = alu_bus.result;
    assign out_rf_we        = uop.rf_we & stage_valid;  // no stale write enables downstream
    assign out_rf_waddr     = uop.rf_waddr;
    assign out_mem_rd       = uop.mem_rd & stage_valid;
    assign out_mem_unsigned = uop.mem_unsigned;

endmodule

/* sim/tb_ex_top.sv */
`timescale 1ns/1ps

module tb_ex_top;

    localparam int n_ops = 320;
    localparam int limit = n_ops * (ex_pkg::div_steps + 8) + 20;

    typedef struct packed {
        logic [31:0] result;
        logic        ale;
        logic [3:0]  wstrb;
        logic [31:0] wdata;
        logic [1:0]  size;
    } exp_t;

    logic            clk = 1'b0;
    logic            resetn;
    logic            id_valid;
    ex_pkg::ex_uop_t drv;  // micro-op on the decode side
    logic            flush;
    logic            mem_allowin;
    logic            data_sram_addr_ok;
    logic            ex_allowin;
    logic            mem_valid;
    logic [31:0]     out_pc;
    logic [31:0]     out_result;
    logic            out_rf_we;
    logic [4:0]      out_rf_waddr;
    logic            out_mem_rd;
    logic            out_mem_unsigned;
    logic            out_ale;
    logic            data_sram_req;
    logic            data_sram_wr;
    logic [1:0]      data_sram_size;
    logic [3:0]      data_sram_wstrb;
    logic [31:0]     data_sram_addr;
    logic [31:0]     data_sram_wdata;

    int seed = 2886;
    int cycles = 0;
    int errors = 0;
    int req_seen = 0;  // requests accepted for the uop in the stage
    int retired = 0;
    int killed = 0;
    logic bp_on;
    logic ok_rand;
    logic hold_ok;  // keeps addr_ok low so a flush finds the request pending
    ex_pkg::ex_uop_t uop_q[$];
    int cyc_q[$];

    ex_top #(.xlen(32)) ex_top_i (
        .clk (clk), .resetn (resetn), .id_valid (id_valid),
        .in_pc (drv.pc), .in_alu_op (drv.alu_op), .in_src1 (drv.src1), .in_src2 (drv.src2),
        .in_rkd (drv.rkd), .in_mem_rd (drv.mem_rd), .in_mem_we (drv.mem_we),
        .in_mem_size (drv.mem_size), .in_mem_unsigned (drv.mem_unsigned),
        .in_rf_we (drv.rf_we), .in_rf_waddr (drv.rf_waddr), .ex_allowin (ex_allowin),
        .flush (flush), .mem_allowin (mem_allowin), .mem_valid (mem_valid),
        .out_pc (out_pc), .out_result (out_result), .out_rf_we (out_rf_we),
        .out_rf_waddr (out_rf_waddr), .out_mem_rd (out_mem_rd),
        .out_mem_unsigned (out_mem_unsigned), .out_ale (out_ale),
        .data_sram_req (data_sram_req), .data_sram_wr (data_sram_wr),
        .data_sram_size (data_sram_size), .data_sram_wstrb (data_sram_wstrb),
        .data_sram_addr (data_sram_addr), .data_sram_wdata (data_sram_wdata),
        .data_sram_addr_ok (data_sram_addr_ok)
    );

    always #20 clk = ~clk;

    function automatic exp_t ref_ex(input ex_pkg::ex_uop_t u);
        exp_t   e;
        longint a;
        longint b;
        e = '0;
        a = longint'($signed(u.src1));
        b = longint'($signed(u.src2));
        case (u.alu_op)
            ex_pkg::alu_add:  e.result = u.src1 + u.src2;
            ex_pkg::alu_sub:  e.result = u.src1 - u.src2;
            ex_pkg::alu_and:  e.result = u.src1 & u.src2;
            ex_pkg::alu_or:   e.result = u.src1 | u.src2;
            ex_pkg::alu_xor:  e.result = u.src1 ^ u.src2;
            ex_pkg::alu_nor:  e.result = ~(u.src1 | u.src2);
            ex_pkg::alu_sll:  e.result = u.src1 << u.src2[4:0];
            ex_pkg::alu_srl:  e.result = u.src1 >> u.src2[4:0];
            ex_pkg::alu_sra:  e.result = $signed(u.src1) >>> u.src2[4:0];
            ex_pkg::alu_slt:  e.result = {31'b0, a < b};
            ex_pkg::alu_sltu: e.result = {31'b0, u.src1 < u.src2};
            ex_pkg::alu_mul:  e.result = u.src1 * u.src2;
            ex_pkg::alu_div:  e.result = (b == 0) ? '1 : 32'(a / b);  // 64-bit divide never overflows
            ex_pkg::alu_divu: e.result = (u.src2 == 0) ? '1 : u.src1 / u.src2;
            ex_pkg::alu_mod:  e.result = (b == 0) ? u.src1 : 32'(a % b);
            default:          e.result = (u.src2 == 0) ? u.src1 : u.src1 % u.src2;
        endcase
        e.size = u.mem_size;
        e.ale  = (u.mem_rd | u.mem_we)
               & (((u.mem_size == ex_pkg::size_half) & e.result[0])
               | ((u.mem_size == ex_pkg::size_word) & (e.result[1:0] != 2'b00)));
        case (u.mem_size)
            ex_pkg::size_byte: begin
                e.wstrb = 4'b0001 << e.result[1:0];
                e.wdata = {4{u.rkd[7:0]}};
            end
            ex_pkg::size_half: begin
                e.wstrb = e.result[1] ? 4'b1100 : 4'b0011;
                e.wdata = {2{u.rkd[15:0]}};
            end
            default: begin
                e.wstrb = 4'b1111;
                e.wdata = u.rkd;
            end
        endcase
        return e;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Errors found");
            $fatal(1);
        end
    end

    // sampled mid-cycle before the edge that completes each handshake
    always @(negedge clk) begin
        exp_t            e;
        ex_pkg::ex_uop_t u;
        int              c;
        if (resetn) begin
            if (data_sram_req && data_sram_addr_ok) begin
                if (uop_q.size() == 0) begin
                    $display("SRAM request accepted while the stage holds no micro-op");
                    $display("Errors found");
                    $fatal(1);
                end
                e = ref_ex(uop_q[0]);
                check_val("data_sram_addr", data_sram_addr, e.result);
                check_val("data_sram_wr", data_sram_wr, uop_q[0].mem_we);
                check_val("data_sram_size", data_sram_size, e.size);
                if (uop_q[0].mem_we) begin
                    check_val("data_sram_wstrb", data_sram_wstrb, e.wstrb);
                    check_val("data_sram_wdata", data_sram_wdata, e.wdata);
                end
                req_seen++;
            end
            if (flush) begin
                if (uop_q.size() != 0) begin  // killed in the stage
                    check_val("mem_valid", mem_valid, 1'b0);
                    check_val("requests of flushed uop", req_seen, 0);
                    void'(uop_q.pop_front());
                    void'(cyc_q.pop_front());
                    req_seen = 0;
                    killed++;
                end
            end else begin
                check_val("ex_allowin", ex_allowin,
                          uop_q.size() == 0 || (mem_valid && mem_allowin));
                if (uop_q.size() == 0) begin  // empty stage sends no enables
                    check_val("out_rf_we", out_rf_we, 1'b0);
                    check_val("out_mem_rd", out_mem_rd, 1'b0);
                end
                if (mem_valid && mem_allowin) begin
                    if (uop_q.size() == 0) begin
                        $display("mem_valid handed over a micro-op that was never sent");
                        $display("Errors found");
                        $fatal(1);
                    end
                    u = uop_q.pop_front();
                    c = cyc_q.pop_front();
                    e = ref_ex(u);
                    check_val("out_pc", out_pc, u.pc);
                    check_val("out_result", out_result, e.result);
                    check_val("out_ale", out_ale, e.ale);
                    check_val("out_rf_we", out_rf_we, u.rf_we);
                    check_val("out_rf_waddr", out_rf_waddr, u.rf_waddr);
                    check_val("out_mem_rd", out_mem_rd, u.mem_rd);
                    check_val("out_mem_unsigned", out_mem_unsigned, u.mem_unsigned);
                    check_val("request count", req_seen, (u.mem_rd | u.mem_we) & ~e.ale);
                    if (!bp_on && u.alu_op < ex_pkg::alu_div && !(u.mem_rd | u.mem_we))
                        check_val("mem_valid latency", cycles - c, 1);
                    req_seen = 0;
                    retired++;
                end
            end
            if (id_valid && ex_allowin) begin
                uop_q.push_back(drv);
                cyc_q.push_back(cycles);
            end
        end
    end

    // advance one cycle and change inputs just after the edge
    task automatic step();
        logic [31:0] r;
        @(posedge clk);
        #2;
        r = $random(seed);
        mem_allowin = bp_on ? (r[1:0] != 2'b00) : 1'b1;
        data_sram_addr_ok = hold_ok ? 1'b0 : (ok_rand ? (r[3:2] != 2'b00) : 1'b1);
    endtask

    task automatic make_uop(input int i, input int kind, output ex_pkg::ex_uop_t u);
        logic [31:0] r;
        logic [1:0]  sel;
        logic [31:0] mask;
        u = '0;
        u.pc   = 32'h1c00_0000 + 32'(i) * 4;
        u.src1 = $random(seed);
        u.src2 = $random(seed);
        u.rkd  = $random(seed);
        r = $random(seed);
        u.rf_we        = r[5];
        u.rf_waddr     = r[10:6];
        u.mem_unsigned = r[11];
        sel = (i < 240) ? 2'((i / 4) % 4) : r[13:12];  // every corner for every divide
        if (kind == 0) begin
            u.alu_op = ex_pkg::alu_op_t'(i % 12);
        end else if (kind == 1) begin
            u.alu_op = ex_pkg::alu_op_t'(12 + i % 4);
            if (sel == 2'd1) begin
                u.src2 = '0;
            end else if (sel == 2'd2) begin
                u.src1 = 32'h8000_0000;
                u.src2 = '1;
            end else if (sel == 2'd3) begin
                u.src2 = {29'b0, r[16:14]} ^ {32{r[17]}};  // small value of either sign
            end
        end else begin
            u.alu_op   = ex_pkg::alu_add;
            u.src2     = {20'b0, r[27:16]};
            u.mem_we   = r[0];
            u.mem_rd   = ~r[0];
            u.mem_size = ex_pkg::mem_size_t'((r[2:1] == 2'd3) ? 2'd2 : r[2:1]);
            mask = (u.mem_size == ex_pkg::size_half) ? 32'd1 :
                   (u.mem_size == ex_pkg::size_word) ? 32'd3 : 32'd0;
            if (r[4:3] != 2'b00)
                u.src1 = u.src1 - ((u.src1 + u.src2) & mask);  // mostly aligned
        end
    endtask

    task automatic send_uop(input ex_pkg::ex_uop_t u);
        logic accepted;
        drv = u;
        id_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = ex_allowin;
            step();
        end
        id_valid = 1'b0;
    endtask

    initial begin
        ex_pkg::ex_uop_t u;
        logic [31:0]     r;
        int              kind;
        int              i;
        resetn = 1'b0;
        id_valid = 1'b0;
        drv = '0;
        flush = 1'b0;
        mem_allowin = 1'b1;
        data_sram_addr_ok = 1'b0;
        bp_on = 1'b0;
        ok_rand = 1'b0;
        hold_ok = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;
        for (i = 0; i < n_ops; i++) begin
            r = $random(seed);
            if (i == 160)
                ok_rand = 1'b1;
            if (i == 240)
                bp_on = 1'b1;
            if (i < 96)
                kind = 0;
            else if (i < 160)
                kind = 1;
            else if (i < 240)
                kind = 2;
            else
                kind = (r[1:0] == 2'd1) ? 1 : (r[1:0] == 2'd2) ? 2 : 0;
            make_uop(i, kind, u);
            send_uop(u);
            r = $random(seed);
            if (bp_on && r[0] && (u.alu_op >= ex_pkg::alu_div || u.mem_we)) begin
                hold_ok = u.mem_we;
                if (hold_ok)
                    data_sram_addr_ok = 1'b0;
                repeat (1 + r[3:1]) step();  // well before the divide ends
                flush = 1'b1;
                data_sram_addr_ok = 1'b1;  // a request that slips past the flush gets taken
                step();
                flush = 1'b0;
                hold_ok = 1'b0;
            end
        end
        while (uop_q.size() != 0)
            step();
        repeat (4) step();
        check_val("retired plus flushed", retired + killed, n_ops);
        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

/* list.f */
rtl/ex_pkg.sv
rtl/ex_alu_if.sv
rtl/ex_ctrl.sv
rtl/ex_alu.sv
rtl/ex_mem_req.sv
rtl/ex_top.sv
sim/tb_ex_top.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_ex_top -o sim_ex_top \
    && ./obj_dir/sim_ex_top | tee /dev/stderr | grep -q "No errors" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
